/* src/em_reg_pkg.sv */
// ----------------------------------------------------------
// Register bus request and response structs, register map
// and the control levels sent to the extraction core
// ----------------------------------------------------------
`default_nettype none

package em_reg_pkg;

  // Reduced AXI-Lite request from the bus master
  typedef struct packed {
    logic [31:0] awaddr;
    logic [31:0] wdata;
    logic        awvalid;
    logic        wvalid;
    logic [31:0] araddr;
    logic        arvalid;
    logic        bready;
    logic        rready;
  } axil_req_t;

  // Response side, one ready shared by address and data writes
  typedef struct packed {
    logic        wready;
    logic        bvalid;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
  } axil_rsp_t;

  // Byte offsets inside the register window
  localparam logic [31:0] REG_SW_RST    = 32'h0;
  localparam logic [31:0] REG_ENABLE    = 32'h4;
  localparam logic [31:0] REG_PKT_COUNT = 32'h8;

  // Levels from the register block to the core
  typedef struct packed {
    logic sw_rst;
    logic em_enable;
  } em_ctrl_t;

endpackage

`default_nettype wire

/* src/em_stream_pkg.sv */
// ----------------------------------------------------------
// Stream beat, metadata header layout and the union used to
// read a packet's first beat
// ----------------------------------------------------------
`default_nettype none

package em_stream_pkg;

  // Stream data width in bits
  localparam int DATA_W = 64;

  // Sideband width carried with each output beat
  localparam int TUSER_W = 128;

  // One stream beat
  // keep has one bit per data byte
  typedef struct packed {
    logic [DATA_W-1:0]   data;
    logic [DATA_W/8-1:0] keep;
    logic                last;
  } em_beat_t;

  // Metadata header as found in the first beat
  // Timestamp sits in the upper word
  // pkt_len lands in the low 16 bits of the raw word
  typedef struct packed {
    logic [31:0] timestamp;
    logic [7:0]  dst_port;
    logic [7:0]  src_port;
    logic [15:0] pkt_len;
  } em_meta_t;

  // First beat seen either as header fields or as plain data
  // Both views are exactly one data word wide
  typedef union packed {
    em_meta_t          meta;
    logic [DATA_W-1:0] raw;
  } em_first_u;

endpackage

`default_nettype wire

/* src/em_ctrl_regs.sv */
// ----------------------------------------------------------
// AXI-Lite register slave with soft reset, enable and a
// count of completed output packets
// ----------------------------------------------------------
`default_nettype none

module em_ctrl_regs import em_reg_pkg::*; #(
  parameter logic [31:0] BASE_ADDR = 32'h0
) (
  input  wire            axi_aclk,
  input  wire            rst,
  input  wire axil_req_t req,
  output axil_rsp_t      rsp,
  output em_ctrl_t       ctrl,
  input  wire            pkt_done
);

  // Offsets relative to the window base
  logic [31:0] wr_off;
  logic [31:0] rd_off;

  // Handshake state for both channels
  logic        wready_q;
  logic        bvalid_q;
  logic        arready_q;
  logic        rvalid_q;
  logic [31:0] rdata_q;

  // Completed transfers
  logic        wr_xfer;
  logic        rd_xfer;

  // Register contents
  logic        sw_rst_q;
  logic        enable_q;
  logic [31:0] pkt_count;

  // Read data selected by offset
  logic [31:0] rd_mux;

  assign wr_off = req.awaddr - BASE_ADDR;
  assign rd_off = req.araddr - BASE_ADDR;

  // Write lands in the cycle the shared ready is high
  assign wr_xfer = wready_q & req.awvalid & req.wvalid;
  assign rd_xfer = arready_q & req.arvalid;

  // Write channel
  always_ff @(posedge axi_aclk) begin
    if (rst) begin
      wready_q <= 1'b0;
      bvalid_q <= 1'b0;
    end else begin
      // Single-cycle ready, none while a response is pending
      wready_q <= req.awvalid & req.wvalid & ~wready_q & ~bvalid_q;
      if (wr_xfer) begin
        bvalid_q <= 1'b1;
      end else if (bvalid_q && req.bready) begin
        bvalid_q <= 1'b0;
      end
    end
  end

  // Writable bits, only bit 0 of each control register
  always_ff @(posedge axi_aclk) begin
    if (rst) begin
      sw_rst_q <= 1'b0;
      enable_q <= 1'b0;
    end else if (wr_xfer) begin
      if (wr_off == REG_SW_RST) begin
        sw_rst_q <= req.wdata[0];
      end
      if (wr_off == REG_ENABLE) begin
        enable_q <= req.wdata[0];
      end
      // PKT_COUNT and unmapped offsets drop the write
    end
  end

  // Output packet counter
  // Soft reset clears it as well
  always_ff @(posedge axi_aclk) begin
    if (rst || sw_rst_q) begin
      pkt_count <= '0;
    end else if (pkt_done) begin
      pkt_count <= pkt_count + 32'd1;
    end
  end

  // Read decode
  always_comb begin
    case (rd_off)
      REG_SW_RST:    rd_mux = {31'b0, sw_rst_q};
      REG_ENABLE:    rd_mux = {31'b0, enable_q};
      REG_PKT_COUNT: rd_mux = pkt_count;
      default:       rd_mux = '0;
    endcase
  end

  // Read channel
  always_ff @(posedge axi_aclk) begin
    if (rst) begin
      arready_q <= 1'b0;
      rvalid_q  <= 1'b0;
    end else begin
      // Pulse ready once per read, then wait for rready
      arready_q <= req.arvalid & ~arready_q & ~rvalid_q;
      if (rd_xfer) begin
        rvalid_q <= 1'b1;
      end else if (rvalid_q && req.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // Read data held with rvalid
  always_ff @(posedge axi_aclk) begin
    if (rd_xfer) begin
      rdata_q <= rd_mux;
    end
  end

  assign rsp = '{
    wready:  wready_q,
    bvalid:  bvalid_q,
    arready: arready_q,
    rvalid:  rvalid_q,
    rdata:   rdata_q
  };

  assign ctrl = '{sw_rst: sw_rst_q, em_enable: enable_q};

endmodule

`default_nettype wire

/* src/em_extract_core.sv */
// ----------------------------------------------------------
// Metadata extraction core: drops the header beat and
// carries its fields on tuser for the packet body
// ----------------------------------------------------------
`default_nettype none

module em_extract_core import em_reg_pkg::*; import em_stream_pkg::*; #(
  parameter int TS_POS = 32
) (
  input  wire                axi_aclk,
  input  wire                rst,
  input  wire em_ctrl_t      ctrl,
  input  wire em_beat_t      s_axis,
  input  wire                s_axis_valid,
  output logic               s_axis_ready,
  output em_beat_t           m_axis,
  output logic [TUSER_W-1:0] m_axis_tuser,
  output logic               m_axis_valid,
  input  wire                m_axis_ready,
  output logic               pkt_done
);

  // First beat decoded through the union
  em_first_u          first_beat;

  // High once a packet's first beat has gone in
  logic               in_pkt;

  // Extraction mode latched for the packet in flight
  logic               mode_q;

  // Input side events
  logic               accept;
  logic               hdr_drop;
  logic               load_out;

  // Sideband built from the header and its holding register
  logic [TUSER_W-1:0] tuser_next;
  logic [TUSER_W-1:0] tuser_q;

  // Single output register
  em_beat_t           out_q;
  logic               out_valid;

  // Header view of the incoming word
  // Only meaningful on a packet's first beat
  always_comb begin
    first_beat.raw = s_axis.data;
  end

  // Sideband layout
  // Ports and length in the low word, timestamp at TS_POS
  always_comb begin
    tuser_next = '0;
    tuser_next[15:0]  = first_beat.meta.pkt_len;
    tuser_next[23:16] = first_beat.meta.src_port;
    tuser_next[31:24] = first_beat.meta.dst_port;
    tuser_next[TS_POS +: 32] = first_beat.meta.timestamp;
  end

  // Room when empty or when the held beat leaves this cycle
  // Soft reset blocks the input entirely
  assign s_axis_ready = ~ctrl.sw_rst & (~out_valid | m_axis_ready);

  assign accept = s_axis_valid & s_axis_ready;

  // Enable is sampled on the first beat only
  assign hdr_drop = ~in_pkt & ctrl.em_enable;

  // Everything but a consumed header goes to the output
  assign load_out = accept & ~hdr_drop;

  // Control state
  always_ff @(posedge axi_aclk) begin
    if (rst || ctrl.sw_rst) begin
      in_pkt    <= 1'b0;
      mode_q    <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      if (accept) begin
        // Back to packet start after the last beat
        in_pkt <= ~s_axis.last;
        if (!in_pkt) begin
          mode_q <= ctrl.em_enable;
        end
      end
      if (load_out) begin
        out_valid <= 1'b1;
      end else if (m_axis_ready) begin
        out_valid <= 1'b0;
      end
    end
  end

  // Payload registers
  always_ff @(posedge axi_aclk) begin
    if (load_out) begin
      out_q <= s_axis;
    end
    // Previous packet has fully left by the time a new header is taken
    if (accept && hdr_drop) begin
      tuser_q <= tuser_next;
    end
  end

  assign m_axis       = out_q;
  assign m_axis_valid = out_valid & ~ctrl.sw_rst;

  // Zero sideband for pass-through packets
  assign m_axis_tuser = mode_q ? tuser_q : '0;

  // One pulse per packet leaving the core
  assign pkt_done = m_axis_valid & m_axis_ready & m_axis.last;

endmodule

`default_nettype wire

/* src/nf_extract_metadata.sv */
// ----------------------------------------------------------
// Top level: register block beside the extraction core
// ----------------------------------------------------------
`default_nettype none

module nf_extract_metadata import em_reg_pkg::*; import em_stream_pkg::*; #(
  parameter int          TS_POS    = 32,
  parameter logic [31:0] BASE_ADDR = 32'h0
) (
  input  wire                axi_aclk,
  input  wire                rst,

  // Register bus
  input  wire axil_req_t     s_axil,
  output axil_rsp_t          s_axil_rsp,

  // Input stream
  input  wire em_beat_t      s_axis,
  input  wire                s_axis_valid,
  output logic               s_axis_ready,

  // Output stream with sideband
  output em_beat_t           m_axis,
  output logic [TUSER_W-1:0] m_axis_tuser,
  output logic               m_axis_valid,
  input  wire                m_axis_ready
);

  // Control levels to the core
  em_ctrl_t ctrl;

  // Packet completion back to the counter
  logic     pkt_done;

  em_ctrl_regs #(
    .BASE_ADDR (BASE_ADDR)
  ) u_regs (
    .axi_aclk (axi_aclk),
    .rst      (rst),
    .req      (s_axil),
    .rsp      (s_axil_rsp),
    .ctrl     (ctrl),
    .pkt_done (pkt_done)
  );

  em_extract_core #(
    .TS_POS (TS_POS)
  ) u_core (
    .axi_aclk     (axi_aclk),
    .rst          (rst),
    .ctrl         (ctrl),
    .s_axis       (s_axis),
    .s_axis_valid (s_axis_valid),
    .s_axis_ready (s_axis_ready),
    .m_axis       (m_axis),
    .m_axis_tuser (m_axis_tuser),
    .m_axis_valid (m_axis_valid),
    .m_axis_ready (m_axis_ready),
    .pkt_done     (pkt_done)
  );

endmodule

`default_nettype wire

/* verif/em_tb_model.svh */
// ----------------------------------------------------------
// Reference model: generated packet buffer, expected beats,
// expected tuser and the expected packet count
// ----------------------------------------------------------
`ifndef EM_TB_MODEL_SVH
`define EM_TB_MODEL_SVH

// Beats of the packet being generated
em_beat_t           pkt_buf[0:MAX_BEATS-1];

// Expected output, one entry per output beat
em_beat_t           exp_beat_q[$];
logic [TUSER_W-1:0] exp_tuser_q[$];

// Packets whose last beat should reach the counter
int unsigned        exp_pkt_count;

// Header word to sideband
// Length and ports keep their bit places, timestamp moves up
function automatic logic [TUSER_W-1:0] expect_tuser(input logic [DATA_W-1:0] hdr);
  logic [TUSER_W-1:0] t;
  t = '0;
  t[15:0]  = hdr[15:0];
  t[23:16] = hdr[23:16];
  t[31:24] = hdr[31:24];
  // Upper word of the header is the timestamp
  t[TB_TS_POS +: 32] = hdr[63:32];
  return t;
endfunction

// Expected output for the n beats in pkt_buf
// With extraction on the header beat yields nothing
task automatic model_packet(input int n, input logic extract);
  logic [TUSER_W-1:0] t;
  int                 first;
  t     = extract ? expect_tuser(pkt_buf[0].data) : '0;
  first = extract ? 1 : 0;
  for (int i = first; i < n; i++) begin
    exp_beat_q.push_back(pkt_buf[i]);
    exp_tuser_q.push_back(t);
  end
  // One-beat packet with extraction on never completes
  if (n > first) begin
    exp_pkt_count++;
  end
endtask

`endif

/* verif/tb_extract_metadata.sv */
// ----------------------------------------------------------
// Testbench for the extraction top level with random packets,
// register accesses, compare tasks and a watchdog
// ----------------------------------------------------------
`default_nettype none

module tb_extract_metadata import em_reg_pkg::*, em_stream_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int TB_TS_POS    = 64;
  localparam int MAX_BEATS    = 6;
  // 30 + 30 + 20 + 20 + 20 packets
  localparam int N_PKTS       = 120;
  localparam int WATCH_CYCLES = N_PKTS * MAX_BEATS * 40 + 500;
  // Longest wait for the output to empty after the last input beat
  localparam int DRAIN_CYCLES = 200;

  logic               axi_aclk;
  logic               rst;
  axil_req_t          s_axil;
  axil_rsp_t          s_axil_rsp;
  em_beat_t           s_axis;
  logic               s_axis_valid;
  logic               s_axis_ready;
  em_beat_t           m_axis;
  logic [TUSER_W-1:0] m_axis_tuser;
  logic               m_axis_valid;
  logic               m_axis_ready;

  logic [31:0]        lfsr_state = 32'hb0da3189;
  // Random output stalls when set
  logic               bp_on;
  // Value last written to ENABLE
  logic               extract_on;

  `include "em_tb_model.svh"

  nf_extract_metadata #(
    .TS_POS    (TB_TS_POS),
    .BASE_ADDR (32'h0)
  ) DUT (
    .axi_aclk     (axi_aclk),
    .rst          (rst),
    .s_axil       (s_axil),
    .s_axil_rsp   (s_axil_rsp),
    .s_axis       (s_axis),
    .s_axis_valid (s_axis_valid),
    .s_axis_ready (s_axis_ready),
    .m_axis       (m_axis),
    .m_axis_tuser (m_axis_tuser),
    .m_axis_valid (m_axis_valid),
    .m_axis_ready (m_axis_ready)
  );

  initial begin
    axi_aclk = 1'b0;
    forever #10 axi_aclk = ~axi_aclk;
  end

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h80200003 : lfsr_state >> 1;
    end
    return r;
  endfunction

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_beat(input em_beat_t exp, input em_beat_t act);
    if (act !== exp) begin
      stop_run($sformatf("FAILED at %0t ns: m_axis expected %h, got %h", $time, exp, act));
    end
  endtask

  task automatic check_tuser(input logic [TUSER_W-1:0] exp, input logic [TUSER_W-1:0] act);
    if (act !== exp) begin
      stop_run($sformatf("FAILED at %0t ns: m_axis_tuser expected %h, got %h",
                         $time, exp, act));
    end
  endtask

  task automatic check_rdata(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      stop_run($sformatf("FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act));
    end
  endtask

  // Every bus task starts and ends 2 ns after a rising edge
  task automatic reg_write(input logic [31:0] addr, input logic [31:0] data);
    s_axil.awaddr  = addr;
    s_axil.wdata   = data;
    s_axil.awvalid = 1'b1;
    s_axil.wvalid  = 1'b1;
    s_axil.bready  = 1'b1;
    @(negedge axi_aclk);
    while (!s_axil_rsp.wready) @(negedge axi_aclk);
    @(posedge axi_aclk);
    #2;
    s_axil.awvalid = 1'b0;
    s_axil.wvalid  = 1'b0;
    @(negedge axi_aclk);
    while (!s_axil_rsp.bvalid) @(negedge axi_aclk);
    @(posedge axi_aclk);
    #2;
  endtask

  task automatic expect_reg(input string name, input logic [31:0] addr, input logic [31:0] exp);
    logic [31:0] val;
    s_axil.araddr  = addr;
    s_axil.arvalid = 1'b1;
    s_axil.rready  = 1'b1;
    @(negedge axi_aclk);
    while (!s_axil_rsp.arready) @(negedge axi_aclk);
    @(posedge axi_aclk);
    #2;
    s_axil.arvalid = 1'b0;
    @(negedge axi_aclk);
    while (!s_axil_rsp.rvalid) @(negedge axi_aclk);
    val = s_axil_rsp.rdata;
    @(posedge axi_aclk);
    #2;
    check_rdata(name, exp, val);
  endtask

  task automatic set_enable(input logic v);
    reg_write(REG_ENABLE, {31'b0, v});
    extract_on = v;
  endtask

  // Random packet of 1 to 6 beats with random input gaps
  task automatic send_packet();
    int n;
    n = 1 + lfsr_bits(3) % 6;
    for (int i = 0; i < n; i++) begin
      pkt_buf[i].data = {lfsr_bits(32), lfsr_bits(32)};
      pkt_buf[i].keep = 8'(lfsr_bits(8));
      pkt_buf[i].last = (i == n - 1);
    end
    model_packet(n, extract_on);
    for (int i = 0; i < n; i++) begin
      if (lfsr_bits(1)) begin
        repeat (lfsr_bits(2)) begin
          @(posedge axi_aclk);
          #2;
        end
      end
      s_axis       = pkt_buf[i];
      s_axis_valid = 1'b1;
      @(negedge axi_aclk);
      while (!s_axis_ready) @(negedge axi_aclk);
      @(posedge axi_aclk);
      #2;
      s_axis_valid = 1'b0;
    end
  endtask

  // Let the model queue run dry, then settle the counter
  task automatic drain();
    int waited;
    waited = 0;
    while (exp_beat_q.size() != 0 && waited < DRAIN_CYCLES) begin
      @(posedge axi_aclk);
      waited++;
    end
    if (exp_beat_q.size() != 0) begin
      stop_run("The model still holds beats that never came out");
    end else begin
      repeat (2) @(posedge axi_aclk);
      #2;
    end
  endtask

  // Output ready toggles randomly only while stalls are on
  initial begin
    forever begin
      @(posedge axi_aclk);
      #2;
      m_axis_ready = bp_on ? 1'(lfsr_bits(1)) : 1'b1;
    end
  end

  // Output monitor samples mid-cycle
  initial begin
    forever begin
      @(negedge axi_aclk);
      if (m_axis_valid && m_axis_ready) begin
        if (exp_beat_q.size() == 0) begin
          stop_run("An output beat appeared while the model expected none");
        end else begin
          check_beat(exp_beat_q.pop_front(), m_axis);
          check_tuser(exp_tuser_q.pop_front(), m_axis_tuser);
        end
      end
    end
  end

  initial begin
    repeat (WATCH_CYCLES) @(posedge axi_aclk);
    stop_run("Timeout: the run did not finish within the expected number of cycles");
  end

  initial begin
    rst           = 1'b1;
    s_axil        = '0;
    s_axis        = '0;
    s_axis_valid  = 1'b0;
    m_axis_ready  = 1'b0;
    bp_on         = 1'b0;
    extract_on    = 1'b0;
    exp_pkt_count = 0;
    repeat (3) @(posedge axi_aclk);
    #2;
    rst = 1'b0;
    // Defaults first, then bit 0 write-back and ignored writes
    expect_reg("SW_RST", REG_SW_RST, 32'h0);
    expect_reg("ENABLE", REG_ENABLE, 32'h0);
    expect_reg("PKT_COUNT", REG_PKT_COUNT, 32'h0);
    reg_write(REG_ENABLE, 32'hffff_ffff);
    expect_reg("ENABLE", REG_ENABLE, 32'h1);
    reg_write(REG_ENABLE, 32'h0000_0002);
    expect_reg("ENABLE", REG_ENABLE, 32'h0);
    reg_write(REG_SW_RST, 32'h1);
    expect_reg("SW_RST", REG_SW_RST, 32'h1);
    reg_write(REG_SW_RST, 32'h0);
    expect_reg("SW_RST", REG_SW_RST, 32'h0);
    reg_write(REG_PKT_COUNT, 32'h0000_1234);
    expect_reg("PKT_COUNT", REG_PKT_COUNT, 32'h0);
    reg_write(32'h40, 32'h1);
    expect_reg("unmapped rdata", 32'h40, 32'h0);
    // Pass-through, then extraction
    repeat (30) send_packet();
    drain();
    expect_reg("PKT_COUNT", REG_PKT_COUNT, exp_pkt_count);
    set_enable(1'b1);
    repeat (30) send_packet();
    drain();
    expect_reg("PKT_COUNT", REG_PKT_COUNT, exp_pkt_count);
    // Output stalls in both modes
    bp_on = 1'b1;
    repeat (20) send_packet();
    set_enable(1'b0);
    repeat (20) send_packet();
    drain();
    expect_reg("PKT_COUNT", REG_PKT_COUNT, exp_pkt_count);
    // Soft reset pulse clears the count
    reg_write(REG_SW_RST, 32'h1);
    reg_write(REG_SW_RST, 32'h0);
    exp_pkt_count = 0;
    expect_reg("PKT_COUNT", REG_PKT_COUNT, 32'h0);
    // Mode flips between packets
    repeat (20) begin
      set_enable(1'(lfsr_bits(1)));
      send_packet();
    end
    drain();
    expect_reg("PKT_COUNT", REG_PKT_COUNT, exp_pkt_count);
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

/* nf_extract_metadata.f */
+incdir+verif
src/em_reg_pkg.sv
src/em_stream_pkg.sv
src/em_ctrl_regs.sv
src/em_extract_core.sv
src/nf_extract_metadata.sv
verif/tb_extract_metadata.sv
